/* tb.f */
+incdir+hdl
hdl/mcoc_pkg.sv
hdl/bus_decode.sv
hdl/gpio_port.sv
hdl/timer_regs.sv
hdl/timer_counter.sv
hdl/irq_ctrl.sv
hdl/mcoc_periph_top.sv
verif/tb_top.sv

/* verif/tb_stimulus.txt */
# op addr data name ; WR write, RD read and compare, CHK output select in addr
# PIN poll limit, INT line in addr, PWM output in addr and window/high in data, WIRQ limit
CHK 0000 0000 rst_irq
CHK 0002 0000 rst_port
CHK 0003 0000 rst_pwm
CHK 0004 0000 rst_rdata
RD 0000 1150 id_code
RD 0001 0148 id_version
RD 0002 5dc0 id_fcpu_khz
RD 0050 0000 unmapped_read
WR 0010 00a5 port_out_wr
WR 0011 003c port_enb_wr
RD 0010 00a5 port_out_rb
RD 0011 003c port_enb_rb
CHK 0002 3ca5 port_pins
PIN 0012 0008 port_in_sync
WR 0021 0009 tim0_period
WR 0022 0003 tim0_cmpa
WR 0023 0007 tim0_cmpb
WR 0020 0001 tim0_enable
IDL 0000 0002 tim0_settle
PWM 0000 0a03 tim0_pwma_duty
PWM 0001 0a07 tim0_pwmb_duty
WR 0031 0005 tim1_period
WR 0032 0001 tim1_cmpa
WR 0030 0001 tim1_enable
IDL 0000 0002 tim1_settle
PWM 0002 0601 tim1_pwma_duty
WR 0030 0000 tim1_disable
IDL 0000 0002 tim1_stop
PWM 0002 0600 tim1_pwma_off
WR 0020 0000 tim0_disable
IDL 0000 0002 tim0_stop
WR 0040 00ff intc_clear_all
WR 0041 0004 intc_mask_ovf0
CHK 0000 0000 irq_idle
WR 0020 0001 tim0_restart
WIRQ 0000 000e tim0_ovf_irq
CHK 0001 0002 tim0_ovf_vec
RD 0040 001c tim0_pending
WR 0020 0000 tim0_halt
IDL 0000 0002 tim0_halt_wait
WR 0040 0004 intc_clear_ovf0
CHK 0000 0000 irq_dropped
WR 0040 00ff ext_clear_all
WR 0041 0003 ext_mask_both
INT 0001 0000 pulse_int1
INT 0000 0000 pulse_int0
CHK 0001 0000 ext_vec_int0
RD 0040 0003 ext_pending
WR 0040 0001 ext_clear_int0
CHK 0001 0001 ext_vec_int1
WR 0040 00ff ext_clear_again
WR 0041 0002 ext_mask_int1
INT 0000 0000 pulse_int0_masked
CHK 0000 0000 masked_irq
RD 0040 0001 masked_pending

/* verif/tb_top.sv */
`default_nettype none

module tb_top;

	logic clk = 1'b0;
	logic rst_n_i;
	logic bus_rd_i;
	logic bus_wr_i;
	mcoc_pkg::bus_addr_t bus_addr_i;
	mcoc_pkg::bus_data_t bus_wdata_i;
	mcoc_pkg::port_t port_in_i;
	logic int0_i;
	logic int1_i;
	mcoc_pkg::bus_data_t bus_rdata_o;
	mcoc_pkg::port_t port_out_o;
	mcoc_pkg::port_t port_enb_o;
	logic tim0_pwma_o, tim0_pwmb_o, tim1_pwma_o, tim1_pwmb_o;
	logic irq_o;
	mcoc_pkg::irq_vec_t irq_vec_o;

	integer seed = 11416;	// Port pattern seed
	integer errors = 0;

	mcoc_periph_top DUT (.*);

	always #10 clk = ~clk;	// 20 unit period

	task automatic stop_run();
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check(input logic [8*32-1:0] name, input logic [15:0] exp,
		input logic [15:0] act);
		if (exp !== act) begin
			errors = errors + 1;
			$display("[FAIL] %0s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	// Select codes of the stimulus file
	function automatic logic [15:0] output_value(input logic [15:0] sel);
		case (sel)
			16'd0: output_value = {15'd0, irq_o};
			16'd1: output_value = {13'd0, irq_vec_o};
			16'd2: output_value = {port_enb_o, port_out_o};
			16'd3: output_value = {12'd0, tim1_pwmb_o, tim1_pwma_o, tim0_pwmb_o, tim0_pwma_o};
			default: output_value = bus_rdata_o;	// Idle bus
		endcase
	endfunction

	task automatic bus_write(input logic [15:0] addr, input logic [15:0] data);
		@(negedge clk);
		bus_wr_i = 1'b1;
		bus_addr_i = addr;
		bus_wdata_i = data;
		@(negedge clk);
		bus_wr_i = 1'b0;	// Single-cycle strobe
	endtask

	task automatic bus_read(input logic [15:0] addr, input logic [8*32-1:0] name,
		output logic [15:0] data);
		@(negedge clk);
		bus_rd_i = 1'b1;
		bus_addr_i = addr;
		@(negedge clk);
		bus_rd_i = 1'b0;
		data = bus_rdata_o;	// Held from the sampling edge
		@(negedge clk);
		check(name, 16'h0000, bus_rdata_o);	// Gone one cycle later
	endtask

	// Window length in the high byte, expected high cycles in the low byte
	task automatic measure_pwm(input logic [15:0] sel, input logic [15:0] spec,
		input logic [8*32-1:0] name);
		integer high;
		logic [15:0] lv;
		high = 0;
		for (int i = 0; i < spec[15:8]; i++) begin
			@(negedge clk);
			lv = output_value(16'd3);
			high = high + lv[sel[1:0]];
		end
		check(name, {8'd0, spec[7:0]}, high[15:0]);
	endtask

	task automatic wait_irq(input logic [15:0] limit);
		integer n;
		n = 0;
		while (irq_o !== 1'b1) begin
			if (n >= limit) begin
				$display("Timeout: irq_o did not rise within %0d cycles", limit);
				stop_run();
			end
			@(negedge clk);
			n = n + 1;
		end
	endtask

	task automatic drive_port_input(input logic [15:0] addr, input logic [15:0] limit,
		input logic [8*32-1:0] name);
		logic [31:0] pattern;
		logic [15:0] rd;
		integer n;
		pattern = $random(seed);
		if (pattern[7:0] == port_in_i)
			pattern[7:0] = ~pattern[7:0];	// Pins must change
		@(negedge clk);
		port_in_i = pattern[7:0];
		bus_read(addr, name, rd);
		n = 1;
		while (rd !== {8'd0, pattern[7:0]}) begin	// Two-flop delay
			if (n >= limit) begin
				$display("Timeout: port input %h never read back", pattern[7:0]);
				stop_run();
			end
			bus_read(addr, name, rd);
			n = n + 1;
		end
	endtask

	task automatic pulse_int(input logic [15:0] line);
		@(negedge clk);
		if (line == 16'd0)
			int0_i = 1'b1;
		else
			int1_i = 1'b1;
		@(negedge clk);
		int0_i = 1'b0;
		int1_i = 1'b0;
		repeat (4) @(negedge clk);	// Pending sets 3 edges after the rise
	endtask

	initial begin : run_stimulus
		integer fd;
		integer r;
		integer n_ops;
		logic [8*8-1:0] op;
		logic [15:0] addr;
		logic [15:0] data;
		logic [15:0] rd;
		logic [8*32-1:0] name;
		logic [8*128-1:0] skip;
		bus_rd_i = 1'b0;
		bus_wr_i = 1'b0;
		bus_addr_i = '0;
		bus_wdata_i = '0;
		port_in_i = '0;
		int0_i = 1'b0;
		int1_i = 1'b0;
		rst_n_i = 1'b0;
		repeat (2) @(negedge clk);	// Reset for two cycles
		rst_n_i = 1'b1;
		fd = $fopen("verif/tb_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file verif/tb_stimulus.txt");
			stop_run();
		end
		n_ops = 0;
		r = $fscanf(fd, "%s", op);
		while (r == 1) begin
			if (op == "#") begin
				r = $fgets(skip, fd);	// Rest of a comment line
			end else begin
				r = $fscanf(fd, "%h %h %s", addr, data, name);
				if (r != 3) begin
					$display("Malformed stimulus line after %0d operations", n_ops);
					stop_run();
				end
				case (op)
					"WR": bus_write(addr, data);
					"RD": begin
						bus_read(addr, name, rd);
						check(name, data, rd);
					end
					"CHK": check(name, data, output_value(addr));
					"IDL": repeat (data) @(negedge clk);
					"PWM": measure_pwm(addr, data, name);
					"PIN": drive_port_input(addr, data, name);
					"INT": pulse_int(addr);
					"WIRQ": wait_irq(data);
					default: begin
						$display("Unknown operation %0s in the stimulus file", op);
						stop_run();
					end
				endcase
				n_ops = n_ops + 1;
			end
			r = $fscanf(fd, "%s", op);
		end
		$fclose(fd);
		if (n_ops == 0) begin
			$display("The stimulus file holds no operations");
			stop_run();
		end
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("CHECKS FAILED");
			$fatal(1, "errors found");
		end
	end

endmodule

`default_nettype wire

/* hdl/mcoc_periph_top.sv */
`include "mcoc_config.svh"
`default_nettype none

module mcoc_periph_top (
	input wire clk,
	input wire rst_n_i,
	input wire bus_rd_i,	// Read strobe
	input wire bus_wr_i,	// Write strobe
	input wire mcoc_pkg::bus_addr_t bus_addr_i,
	input wire mcoc_pkg::bus_data_t bus_wdata_i,
	input wire mcoc_pkg::port_t port_in_i,	// Pin levels
	input wire int0_i,	// External interrupt 0
	input wire int1_i,	// External interrupt 1
	output mcoc_pkg::bus_data_t bus_rdata_o,
	output mcoc_pkg::port_t port_out_o,
	output mcoc_pkg::port_t port_enb_o,	// 1 drives the pin
	output logic tim0_pwma_o,
	output logic tim0_pwmb_o,
	output logic tim1_pwma_o,
	output logic tim1_pwmb_o,
	output logic irq_o,
	output mcoc_pkg::irq_vec_t irq_vec_o
);

	mcoc_pkg::reg_ofs_t ofs;	// Shared register offset
	logic port_cs_n, tim0_cs_n, tim1_cs_n, intc_cs_n;	// Block selects
	mcoc_pkg::bus_data_t rdata_port, rdata_tim0, rdata_tim1, rdata_intc;

	logic tim0_en, tim1_en;
	mcoc_pkg::tim_cnt_t tim0_period, tim0_cmpa, tim0_cmpb, tim0_count;
	mcoc_pkg::tim_cnt_t tim1_period, tim1_cmpa, tim1_cmpb, tim1_count;
	logic tim0_ovf, tim0_cma, tim0_cmb;
	logic tim1_ovf, tim1_cma, tim1_cmb;
	logic [5:0] tim_flags;	// Sources 2..7 of the controller

	assign ofs = bus_addr_i[`MCOC_OFS_W-1:0];
	assign tim_flags = {tim1_cmb, tim1_cma, tim1_ovf, tim0_cmb, tim0_cma, tim0_ovf};

	bus_decode u_bus_decode (
		.clk(clk), .rst_n_i(rst_n_i),
		.bus_rd_i(bus_rd_i), .bus_addr_i(bus_addr_i),
		.rdata_port_i(rdata_port), .rdata_tim0_i(rdata_tim0),
		.rdata_tim1_i(rdata_tim1), .rdata_intc_i(rdata_intc),
		.port_cs_n_o(port_cs_n), .tim0_cs_n_o(tim0_cs_n),
		.tim1_cs_n_o(tim1_cs_n), .intc_cs_n_o(intc_cs_n),
		.bus_rdata_o(bus_rdata_o)
	);

	gpio_port u_gpio_port (
		.clk(clk), .rst_n_i(rst_n_i), .cs_n_i(port_cs_n),
		.bus_rd_i(bus_rd_i), .bus_wr_i(bus_wr_i), .ofs_i(ofs), .wdata_i(bus_wdata_i),
		.port_in_i(port_in_i), .rdata_o(rdata_port),
		.port_out_o(port_out_o), .port_enb_o(port_enb_o)
	);

	timer_regs u_tim0_regs (
		.clk(clk), .rst_n_i(rst_n_i), .cs_n_i(tim0_cs_n),
		.bus_rd_i(bus_rd_i), .bus_wr_i(bus_wr_i), .ofs_i(ofs), .wdata_i(bus_wdata_i),
		.tim_count_i(tim0_count), .rdata_o(rdata_tim0), .tim_en_o(tim0_en),
		.tim_period_o(tim0_period), .tim_cmpa_o(tim0_cmpa), .tim_cmpb_o(tim0_cmpb)
	);

	timer_counter u_tim0_cnt (
		.clk(clk), .rst_n_i(rst_n_i), .tim_en_i(tim0_en),
		.tim_period_i(tim0_period), .tim_cmpa_i(tim0_cmpa), .tim_cmpb_i(tim0_cmpb),
		.tim_count_o(tim0_count), .pwma_o(tim0_pwma_o), .pwmb_o(tim0_pwmb_o),
		.ovf_o(tim0_ovf), .cma_o(tim0_cma), .cmb_o(tim0_cmb)
	);

	timer_regs u_tim1_regs (
		.clk(clk), .rst_n_i(rst_n_i), .cs_n_i(tim1_cs_n),
		.bus_rd_i(bus_rd_i), .bus_wr_i(bus_wr_i), .ofs_i(ofs), .wdata_i(bus_wdata_i),
		.tim_count_i(tim1_count), .rdata_o(rdata_tim1), .tim_en_o(tim1_en),
		.tim_period_o(tim1_period), .tim_cmpa_o(tim1_cmpa), .tim_cmpb_o(tim1_cmpb)
	);

	timer_counter u_tim1_cnt (
		.clk(clk), .rst_n_i(rst_n_i), .tim_en_i(tim1_en),
		.tim_period_i(tim1_period), .tim_cmpa_i(tim1_cmpa), .tim_cmpb_i(tim1_cmpb),
		.tim_count_o(tim1_count), .pwma_o(tim1_pwma_o), .pwmb_o(tim1_pwmb_o),
		.ovf_o(tim1_ovf), .cma_o(tim1_cma), .cmb_o(tim1_cmb)
	);

	irq_ctrl u_irq_ctrl (
		.clk(clk), .rst_n_i(rst_n_i), .cs_n_i(intc_cs_n),
		.bus_rd_i(bus_rd_i), .bus_wr_i(bus_wr_i), .ofs_i(ofs), .wdata_i(bus_wdata_i),
		.int0_i(int0_i), .int1_i(int1_i), .tim_flags_i(tim_flags),
		.rdata_o(rdata_intc), .irq_o(irq_o), .irq_vec_o(irq_vec_o)
	);

endmodule

`default_nettype wire

/* hdl/irq_ctrl.sv */
`include "mcoc_config.svh"
`default_nettype none

module irq_ctrl (
	input wire clk,
	input wire rst_n_i,
	input wire cs_n_i,	// Block select
	input wire bus_rd_i,
	input wire bus_wr_i,
	input wire mcoc_pkg::reg_ofs_t ofs_i,
	input wire mcoc_pkg::bus_data_t wdata_i,
	input wire int0_i,	// Asynchronous external request
	input wire int1_i,
	input wire [5:0] tim_flags_i,	// tim0 ovf/cma/cmb then tim1
	output mcoc_pkg::bus_data_t rdata_o,
	output logic irq_o,
	output mcoc_pkg::irq_vec_t irq_vec_o
);

	logic [1:0] ext_s1_q, ext_s2_q, ext_s3_q;	// Sync stages and edge history
	logic [1:0] ext_rise;
	mcoc_pkg::irq_src_t src;	// Events this cycle
	mcoc_pkg::irq_src_t clr;	// Write-1-to-clear bits
	mcoc_pkg::irq_src_t pend_q;
	mcoc_pkg::irq_src_t mask_q;
	mcoc_pkg::irq_src_t active;	// Pending and enabled
	mcoc_pkg::bus_data_t rd_val;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ext_s1_q <= '0;
			ext_s2_q <= '0;
			ext_s3_q <= '0;
		end else begin
			ext_s1_q <= {int1_i, int0_i};
			ext_s2_q <= ext_s1_q;
			ext_s3_q <= ext_s2_q;
		end
	end

	assign ext_rise = ext_s2_q & ~ext_s3_q;	// Pending set on the third edge
	assign src = {tim_flags_i, ext_rise};
	assign clr = (!cs_n_i && bus_wr_i && ofs_i == `MCOC_INTC_PEND) ?
		wdata_i[`MCOC_IRQ_N-1:0] : '0;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pend_q <= '0;
			mask_q <= `MCOC_INTC_RST;
		end else begin
			pend_q <= (pend_q & ~clr) | src;	// New event beats the clear
			if (!cs_n_i && bus_wr_i && ofs_i == `MCOC_INTC_MASK)
				mask_q <= wdata_i[`MCOC_IRQ_N-1:0];
		end
	end

	assign active = pend_q & mask_q;
	assign irq_o = |active;

	always_comb begin
		irq_vec_o = '0;
		for (int i = `MCOC_IRQ_N - 1; i >= 0; i--) begin
			if (active[i]) irq_vec_o = mcoc_pkg::irq_vec_t'(i);	// Lowest bit wins
		end
	end

	always_comb begin
		case (ofs_i)
			`MCOC_INTC_PEND: rd_val = mcoc_pkg::bus_data_t'(pend_q);
			`MCOC_INTC_MASK: rd_val = mcoc_pkg::bus_data_t'(mask_q);
			default: rd_val = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rdata_o <= '0;
		end else begin
			rdata_o <= (!cs_n_i && bus_rd_i) ? rd_val : '0;
		end
	end

endmodule

`default_nettype wire

/* hdl/timer_counter.sv */
`default_nettype none

module timer_counter (
	input wire clk,
	input wire rst_n_i,
	input wire tim_en_i,	// Run enable
	input wire mcoc_pkg::tim_cnt_t tim_period_i,	// Last count before wrap
	input wire mcoc_pkg::tim_cnt_t tim_cmpa_i,
	input wire mcoc_pkg::tim_cnt_t tim_cmpb_i,
	output mcoc_pkg::tim_cnt_t tim_count_o,
	output logic pwma_o,
	output logic pwmb_o,
	output logic ovf_o,	// Wrap pulse
	output logic cma_o,	// Compare A match pulse
	output logic cmb_o	// Compare B match pulse
);

	logic wrap;	// Count at period

	assign wrap = (tim_count_o == tim_period_i);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tim_count_o <= '0;
			pwma_o <= 1'b0;
			pwmb_o <= 1'b0;
			ovf_o <= 1'b0;
			cma_o <= 1'b0;
			cmb_o <= 1'b0;
		end else if (!tim_en_i) begin
			tim_count_o <= '0;	// Held while stopped
			pwma_o <= 1'b0;
			pwmb_o <= 1'b0;
			ovf_o <= 1'b0;
			cma_o <= 1'b0;
			cmb_o <= 1'b0;
		end else begin
			// period+1 counts per timer cycle
			tim_count_o <= wrap ? '0 : tim_count_o + 1'b1;
			ovf_o <= wrap;
			cma_o <= (tim_count_o == tim_cmpa_i);
			cmb_o <= (tim_count_o == tim_cmpb_i);
			pwma_o <= (tim_count_o < tim_cmpa_i);	// High for cmpa counts
			pwmb_o <= (tim_count_o < tim_cmpb_i);
		end
	end

endmodule

`default_nettype wire

/* hdl/timer_regs.sv */
`include "mcoc_config.svh"
`default_nettype none

module timer_regs (
	input wire clk,
	input wire rst_n_i,
	input wire cs_n_i,	// Block select
	input wire bus_rd_i,
	input wire bus_wr_i,
	input wire mcoc_pkg::reg_ofs_t ofs_i,
	input wire mcoc_pkg::bus_data_t wdata_i,
	input wire mcoc_pkg::tim_cnt_t tim_count_i,	// Live count from the counter
	output mcoc_pkg::bus_data_t rdata_o,
	output logic tim_en_o,
	output mcoc_pkg::tim_cnt_t tim_period_o,
	output mcoc_pkg::tim_cnt_t tim_cmpa_o,
	output mcoc_pkg::tim_cnt_t tim_cmpb_o
);

	logic wr_en;	// Write to this timer
	mcoc_pkg::bus_data_t rd_val;

	assign wr_en = !cs_n_i && bus_wr_i;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tim_en_o <= 1'b0;	// Timer stopped
			tim_period_o <= `MCOC_TIM_RST;
			tim_cmpa_o <= `MCOC_TIM_RST;
			tim_cmpb_o <= `MCOC_TIM_RST;
		end else if (wr_en) begin
			case (ofs_i)
				`MCOC_TIM_CTRL: tim_en_o <= wdata_i[0];
				`MCOC_TIM_PRD: tim_period_o <= wdata_i;
				`MCOC_TIM_CMPA: tim_cmpa_o <= wdata_i;
				`MCOC_TIM_CMPB: tim_cmpb_o <= wdata_i;
				default: ;	// Count is read-only
			endcase
		end
	end

	always_comb begin
		case (ofs_i)
			`MCOC_TIM_CTRL: rd_val = {{(`MCOC_DATA_W-1){1'b0}}, tim_en_o};
			`MCOC_TIM_PRD: rd_val = tim_period_o;
			`MCOC_TIM_CMPA: rd_val = tim_cmpa_o;
			`MCOC_TIM_CMPB: rd_val = tim_cmpb_o;
			`MCOC_TIM_CNT: rd_val = tim_count_i;
			default: rd_val = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rdata_o <= '0;
		end else begin
			rdata_o <= (!cs_n_i && bus_rd_i) ? rd_val : '0;	// One-cycle return
		end
	end

endmodule

`default_nettype wire

/* hdl/gpio_port.sv */
`include "mcoc_config.svh"
`default_nettype none

module gpio_port (
	input wire clk,
	input wire rst_n_i,
	input wire cs_n_i,	// Block select
	input wire bus_rd_i,
	input wire bus_wr_i,
	input wire mcoc_pkg::reg_ofs_t ofs_i,
	input wire mcoc_pkg::bus_data_t wdata_i,
	input wire mcoc_pkg::port_t port_in_i,	// Asynchronous pin levels
	output mcoc_pkg::bus_data_t rdata_o,
	output mcoc_pkg::port_t port_out_o,
	output mcoc_pkg::port_t port_enb_o
);

	mcoc_pkg::port_t out_q;	// Output data register
	mcoc_pkg::port_t enb_q;	// Output enable register
	mcoc_pkg::port_t in_s1_q, in_s2_q;	// Two-flop synchronizer
	mcoc_pkg::port_t rd_val;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			out_q <= `MCOC_PORT_RST;
			enb_q <= `MCOC_PORT_RST;	// High impedance after reset
		end else if (!cs_n_i && bus_wr_i) begin
			if (ofs_i == `MCOC_PORT_OUT) out_q <= wdata_i[`MCOC_PORT_W-1:0];
			if (ofs_i == `MCOC_PORT_ENB) enb_q <= wdata_i[`MCOC_PORT_W-1:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			in_s1_q <= '0;
			in_s2_q <= '0;
		end else begin
			in_s1_q <= port_in_i;
			in_s2_q <= in_s1_q;	// Safe to read from here on
		end
	end

	always_comb begin
		case (ofs_i)
			`MCOC_PORT_OUT: rd_val = out_q;
			`MCOC_PORT_ENB: rd_val = enb_q;
			`MCOC_PORT_INP: rd_val = in_s2_q;
			default: rd_val = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rdata_o <= '0;
		end else begin
			rdata_o <= (!cs_n_i && bus_rd_i) ? mcoc_pkg::bus_data_t'(rd_val) : '0;
		end
	end

	assign port_out_o = out_q;
	assign port_enb_o = enb_q;

endmodule

`default_nettype wire

/* hdl/bus_decode.sv */
`include "mcoc_config.svh"
`default_nettype none

module bus_decode (
	input wire clk,
	input wire rst_n_i,
	input wire bus_rd_i,
	input wire mcoc_pkg::bus_addr_t bus_addr_i,
	input wire mcoc_pkg::bus_data_t rdata_port_i,	// Registered block returns
	input wire mcoc_pkg::bus_data_t rdata_tim0_i,
	input wire mcoc_pkg::bus_data_t rdata_tim1_i,
	input wire mcoc_pkg::bus_data_t rdata_intc_i,
	output logic port_cs_n_o,
	output logic tim0_cs_n_o,
	output logic tim1_cs_n_o,
	output logic intc_cs_n_o,
	output mcoc_pkg::bus_data_t bus_rdata_o
);

	logic [`MCOC_ADDR_W-`MCOC_OFS_W-1:0] blk;	// Block number
	mcoc_pkg::reg_ofs_t ofs;
	logic idrg_sel;	// ID block hit
	mcoc_pkg::bus_data_t idrg_val;	// Addressed ID word
	mcoc_pkg::bus_data_t idrg_rdata_q;

	assign blk = bus_addr_i[`MCOC_ADDR_W-1:`MCOC_OFS_W];
	assign ofs = bus_addr_i[`MCOC_OFS_W-1:0];

	// Selects follow the address alone, blocks qualify with the strobes
	assign idrg_sel = (blk == `MCOC_BASE_IDRG);
	assign port_cs_n_o = (blk != `MCOC_BASE_PORT);
	assign tim0_cs_n_o = (blk != `MCOC_BASE_TIM0);
	assign tim1_cs_n_o = (blk != `MCOC_BASE_TIM1);
	assign intc_cs_n_o = (blk != `MCOC_BASE_INTC);

	always_comb begin
		case (ofs)
			`MCOC_IDRG_IDCODE: idrg_val = `MCOC_IDCODE;
			`MCOC_IDRG_VERSNO: idrg_val = `MCOC_VERSNO;
			`MCOC_IDRG_FCPU: idrg_val = `MCOC_FCPU_KHZ;
			default: idrg_val = '0;	// Unused ID offsets
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			idrg_rdata_q <= '0;
		end else if (idrg_sel && bus_rd_i) begin
			idrg_rdata_q <= idrg_val;	// Valid for one cycle
		end else begin
			idrg_rdata_q <= '0;
		end
	end

	// Unselected blocks return zero, so a plain OR merges them
	assign bus_rdata_o = idrg_rdata_q | rdata_port_i | rdata_tim0_i |
		rdata_tim1_i | rdata_intc_i;

endmodule

`default_nettype wire

/* hdl/mcoc_pkg.sv */
`include "mcoc_config.svh"
`default_nettype none

package mcoc_pkg;

	typedef logic [`MCOC_ADDR_W-1:0] bus_addr_t;	// Bus address
	typedef logic [`MCOC_DATA_W-1:0] bus_data_t;	// Bus read and write data
	typedef logic [`MCOC_OFS_W-1:0] reg_ofs_t;	// Offset inside a block

	typedef logic [`MCOC_PORT_W-1:0] port_t;	// One bit per pin

	typedef logic [`MCOC_TIM_W-1:0] tim_cnt_t;	// Count, period and compares

	typedef logic [`MCOC_IRQ_N-1:0] irq_src_t;	// One bit per source
	typedef logic [$clog2(`MCOC_IRQ_N)-1:0] irq_vec_t;	// Source number

endpackage

`default_nettype wire

/* hdl/mcoc_config.svh */
`ifndef MCOC_CONFIG_SVH
`define MCOC_CONFIG_SVH

`define MCOC_ADDR_W	16	// Bus address bits
`define MCOC_DATA_W	16	// Bus data bits
`define MCOC_OFS_W	4	// Register offset bits inside a block
`define MCOC_PORT_W	8	// Port pins
`define MCOC_TIM_W	16	// Timer count bits
`define MCOC_IRQ_N	8	// Interrupt sources

// Block numbers on address bits 15..4
`define MCOC_BASE_IDRG	12'h000	// Identification
`define MCOC_BASE_PORT	12'h001	// Port
`define MCOC_BASE_TIM0	12'h002	// Timer 0
`define MCOC_BASE_TIM1	12'h003	// Timer 1
`define MCOC_BASE_INTC	12'h004	// Interrupt controller

`define MCOC_IDRG_IDCODE	4'h0	// ID code
`define MCOC_IDRG_VERSNO	4'h1	// Version word
`define MCOC_IDRG_FCPU	4'h2	// Clock in kHz
`define MCOC_PORT_OUT	4'h0	// Output data
`define MCOC_PORT_ENB	4'h1	// Output enable
`define MCOC_PORT_INP	4'h2	// Synchronized input
`define MCOC_TIM_CTRL	4'h0	// Control, bit 0 enable
`define MCOC_TIM_PRD	4'h1	// Period
`define MCOC_TIM_CMPA	4'h2	// Compare A
`define MCOC_TIM_CMPB	4'h3	// Compare B
`define MCOC_TIM_CNT	4'h4	// Live count
`define MCOC_INTC_PEND	4'h0	// Pending, write 1 to clear
`define MCOC_INTC_MASK	4'h1	// Mask

`define MCOC_IDCODE	16'h1150	// Part code
`define MCOC_VERSNO	16'h0148	// Version
`define MCOC_FCPU_KHZ	16'd24000	// 24 MHz core clock

`define MCOC_PORT_RST	8'h00	// Port starts undriven
`define MCOC_TIM_RST	16'h0000	// Timer registers
`define MCOC_INTC_RST	8'h00	// All sources masked

`endif
